/* noc_params.svh */
// Build-time sizes for the NoC injection tile
// Address and payload widths, mesh coordinate widths, rule and initiator
// counts, link credit depth and the address bit fields used by XY fallback

`ifndef NOC_PARAMS_SVH
`define NOC_PARAMS_SVH

// Request address and payload
`define NOC_ADDR_W 32
`define NOC_DATA_W 32

// Mesh coordinates
`define NOC_X_W 3
`define NOC_Y_W 3

// Address map and initiator count
`define NOC_NUM_RULES 4
`define NOC_NUM_INIT 2

// Depth of the downstream router input buffer
`define NOC_CREDITS 4

// Bit positions of x and y when no address rule matches
`define NOC_X_OFFSET 16
`define NOC_Y_OFFSET 20

`endif

/* noc_pkg.sv */
// Shared types of the NoC injection tile
// Width typedefs, node ID, address rule and flit structs, port FSM states

`default_nettype none

`include "noc_params.svh"

package noc_pkg;

  typedef logic [`NOC_ADDR_W-1:0] addr_t;
  typedef logic [`NOC_DATA_W-1:0] data_t;
  typedef logic [`NOC_X_W-1:0]    coord_x_t;
  typedef logic [`NOC_Y_W-1:0]    coord_y_t;
  typedef logic [0:0]             src_id_t;

  // Must hold the full credit count, not just count-1
  typedef logic [$clog2(`NOC_CREDITS+1)-1:0] credit_cnt_t;

  typedef struct packed {
    coord_y_t y;
    coord_x_t x;
  } node_id_t;

  // Rule covers start_addr up to, but not including, end_addr
  typedef struct packed {
    node_id_t dst;
    addr_t    start_addr;
    addr_t    end_addr;
  } addr_rule_t;

  typedef struct packed {
    node_id_t dst;
    src_id_t  src;
    addr_t    addr;
    data_t    data;
  } flit_t;

  typedef enum logic {IDLE, HOLD} port_state_e;

endpackage

`default_nettype wire

/* noc_route_comp.sv */
// Address to destination decode for one initiator port
// First-match lookup over the address rule table, with an XY bit-field
// fallback when no rule covers the address

`timescale 1ns/1ns
`default_nettype none

`include "noc_params.svh"

module noc_route_comp (
  input  noc_pkg::addr_t                          addr_i,
  input  noc_pkg::addr_rule_t [`NOC_NUM_RULES-1:0] addr_map_i,
  output noc_pkg::node_id_t                       dst_o
);

  import noc_pkg::*;

  logic [`NOC_NUM_RULES-1:0] rule_hit;
  node_id_t                  xy_dst;

  // Compare against every rule in parallel
  always_comb begin
    for (int i = 0; i < `NOC_NUM_RULES; i++) begin
      rule_hit[i] = (addr_i >= addr_map_i[i].start_addr) &&
                    (addr_i <  addr_map_i[i].end_addr);
    end
  end

  // Destination taken straight from the address, as in plain XY routing
  assign xy_dst.x = addr_i[`NOC_X_OFFSET +: `NOC_X_W];
  assign xy_dst.y = addr_i[`NOC_Y_OFFSET +: `NOC_Y_W];

  // Walk from the highest index down so that the lowest matching rule
  // is the one that sticks
  always_comb begin
    dst_o = xy_dst;
    for (int i = `NOC_NUM_RULES-1; i >= 0; i--) begin
      if (rule_hit[i]) begin
        dst_o = addr_map_i[i].dst;
      end
    end
  end

endmodule

`default_nettype wire

/* noc_init_port.sv */
// Injection port for one local initiator
// Valid/ready request intake, route lookup and an IDLE/HOLD FSM that
// keeps the finished flit until the link arbiter grants it

`timescale 1ns/1ns
`default_nettype none

`include "noc_params.svh"

module noc_init_port (
  input  logic                                    clk_i,
  input  logic                                    rst_i,
  input  logic                                    req_valid_i,
  input  noc_pkg::addr_t                          req_addr_i,
  input  noc_pkg::data_t                          req_data_i,
  output logic                                    req_ready_o,
  input  noc_pkg::addr_rule_t [`NOC_NUM_RULES-1:0] addr_map_i,
  input  noc_pkg::src_id_t                        src_id_i,
  input  logic                                    grant_i,
  output logic                                    pending_o,
  output noc_pkg::flit_t                          flit_o
);

  import noc_pkg::*;

  port_state_e state_q;
  port_state_e state_d;
  node_id_t    route_dst;
  flit_t       flit_q;
  logic        accept;

  noc_route_comp u_route_comp (
    .addr_i     (req_addr_i),
    .addr_map_i (addr_map_i),
    .dst_o      (route_dst)
  );

  // A grant frees the holding slot in the same cycle, which lets a new
  // request in right behind the one leaving
  assign req_ready_o = (state_q == IDLE) || grant_i;
  assign accept      = req_valid_i && req_ready_o;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:    if (accept) state_d = HOLD;
      HOLD:    if (grant_i && !accept) state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Flit is built at acceptance, so the route is fixed from then on
  always_ff @(posedge clk_i) begin
    if (accept) begin
      flit_q.dst  <= route_dst;
      flit_q.src  <= src_id_i;
      flit_q.addr <= req_addr_i;
      flit_q.data <= req_data_i;
    end
  end

  assign pending_o = (state_q == HOLD);
  assign flit_o    = flit_q;

endmodule

`default_nettype wire

/* noc_link_arb.sv */
// Shared link stage of the injection tile
// Round-robin arbiter over the initiator ports, credit counter for the
// downstream buffer and the registered link output

`timescale 1ns/1ns
`default_nettype none

`include "noc_params.svh"

module noc_link_arb (
  input  logic                                clk_i,
  input  logic                                rst_i,
  input  logic [`NOC_NUM_INIT-1:0]            pending_i,
  input  noc_pkg::flit_t [`NOC_NUM_INIT-1:0] flit_i,
  output logic [`NOC_NUM_INIT-1:0]            grant_o,
  output noc_pkg::flit_t                      link_flit_o,
  output logic                                link_valid_o,
  input  logic                                link_credit_i
);

  import noc_pkg::*;

  src_id_t     rr_ptr_q;
  src_id_t     grant_idx;
  logic        grant_any;
  logic        can_send;
  logic        send;
  credit_cnt_t credit_q;
  flit_t       link_flit_q;
  logic        link_valid_q;

  // A credit coming back this cycle can be spent right away
  assign can_send = (credit_q != '0) || link_credit_i;

  // Search starts at the pointer and wraps, nearest pending port wins
  always_comb begin
    src_id_t idx;
    idx       = rr_ptr_q;
    grant_idx = rr_ptr_q;
    grant_any = 1'b0;
    for (int k = `NOC_NUM_INIT-1; k >= 0; k--) begin
      idx = src_id_t'((rr_ptr_q + k) % `NOC_NUM_INIT);
      if (pending_i[idx]) begin
        grant_idx = idx;
        grant_any = 1'b1;
      end
    end
  end

  assign send = grant_any && can_send;

  always_comb begin
    grant_o = '0;
    if (send) begin
      grant_o[grant_idx] = 1'b1;
    end
  end

  // Pointer parks just past the port that was served last
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rr_ptr_q <= '0;
    end else if (send) begin
      rr_ptr_q <= src_id_t'((grant_idx + 1) % `NOC_NUM_INIT);
    end
  end

  // Send and return in one cycle leave the count unchanged
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      credit_q <= credit_cnt_t'(`NOC_CREDITS);
    end else begin
      case ({send, link_credit_i})
        2'b10:   credit_q <= credit_q - 1'b1;
        2'b01:   credit_q <= credit_q + 1'b1;
        default: credit_q <= credit_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      link_valid_q <= 1'b0;
    end else begin
      link_valid_q <= send;
    end
  end

  always_ff @(posedge clk_i) begin
    if (send) begin
      link_flit_q <= flit_i[grant_idx];
    end
  end

  assign link_flit_o  = link_flit_q;
  assign link_valid_o = link_valid_q;

endmodule

`default_nettype wire

/* noc_inject_top.sv */
// Injection side of a mesh NoC tile
// Two initiator ports feeding one credit-controlled link through a
// round-robin arbiter

`timescale 1ns/1ns
`default_nettype none

`include "noc_params.svh"

module noc_inject_top (
  input  logic                                    clk_i,
  input  logic                                    rst_i,
  input  logic [`NOC_NUM_INIT-1:0]                req_valid_i,
  input  noc_pkg::addr_t [`NOC_NUM_INIT-1:0]     req_addr_i,
  input  noc_pkg::data_t [`NOC_NUM_INIT-1:0]     req_data_i,
  output logic [`NOC_NUM_INIT-1:0]                req_ready_o,
  input  noc_pkg::addr_rule_t [`NOC_NUM_RULES-1:0] addr_map_i,
  output noc_pkg::flit_t                          link_flit_o,
  output logic                                    link_valid_o,
  input  logic                                    link_credit_i
);

  import noc_pkg::*;

  logic [`NOC_NUM_INIT-1:0]  port_pending;
  logic [`NOC_NUM_INIT-1:0]  port_grant;
  flit_t [`NOC_NUM_INIT-1:0] port_flit;

  // Loop index doubles as the source ID carried in every flit
  for (genvar g = 0; g < `NOC_NUM_INIT; g++) begin : gen_init_port
    noc_init_port u_init_port (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .req_valid_i (req_valid_i[g]),
      .req_addr_i  (req_addr_i[g]),
      .req_data_i  (req_data_i[g]),
      .req_ready_o (req_ready_o[g]),
      .addr_map_i  (addr_map_i),
      .src_id_i    (src_id_t'(g)),
      .grant_i     (port_grant[g]),
      .pending_o   (port_pending[g]),
      .flit_o      (port_flit[g])
    );
  end

  noc_link_arb u_link_arb (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .pending_i     (port_pending),
    .flit_i        (port_flit),
    .grant_o       (port_grant),
    .link_flit_o   (link_flit_o),
    .link_valid_o  (link_valid_o),
    .link_credit_i (link_credit_i)
  );

endmodule

`default_nettype wire

/* tb_noc_inject_top.sv */
// Testbench for the NoC injection tile
// Random request stimulus, downstream credit model, reference route
// function, per-source scoreboard and typed compare tasks

`timescale 1ns/1ns
`default_nettype none

`include "noc_params.svh"

module tb_noc_inject_top;

  import noc_pkg::*;

  localparam int NUM_REQS       = 160;
  localparam int TIMEOUT_CYCLES = 40 * NUM_REQS + 200;

  logic                             clk_i;
  logic                             rst_i;
  logic [`NOC_NUM_INIT-1:0]         req_valid_i;
  addr_t [`NOC_NUM_INIT-1:0]        req_addr_i;
  data_t [`NOC_NUM_INIT-1:0]        req_data_i;
  logic [`NOC_NUM_INIT-1:0]         req_ready_o;
  addr_rule_t [`NOC_NUM_RULES-1:0]  addr_map_i;
  flit_t                            link_flit_o;
  logic                             link_valid_o;
  logic                             link_credit_i;

  logic [31:0]              rng;
  int                       cycle;
  int                       issued;
  int                       outstanding;
  logic [`NOC_NUM_INIT-1:0] accepted;
  logic                     flit_seen;
  flit_t                    exp_q0[$];
  flit_t                    exp_q1[$];
  int                       credit_due[$];
  logic                     traffic_on;
  logic                     traffic_full;
  logic                     withhold;
  logic                     fast_credit;
  logic                     fair_check;
  logic                     have_last;
  src_id_t                  last_src;

  noc_inject_top u_noc_inject_top (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .req_valid_i   (req_valid_i),
    .req_addr_i    (req_addr_i),
    .req_data_i    (req_data_i),
    .req_ready_o   (req_ready_o),
    .addr_map_i    (addr_map_i),
    .link_flit_o   (link_flit_o),
    .link_valid_o  (link_valid_o),
    .link_credit_i (link_credit_i)
  );

  always #20 clk_i = ~clk_i;

  function automatic logic [31:0] xorshift32(logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic addr_rule_t make_rule(int x, int y, addr_t lo, addr_t hi);
    addr_rule_t r;
    r.dst.x      = coord_x_t'(x);
    r.dst.y      = coord_y_t'(y);
    r.start_addr = lo;
    r.end_addr   = hi;
    return r;
  endfunction

  // The lowest-index rule covering the address wins and unmapped addresses use the XY bits
  function automatic node_id_t route_ref(addr_t addr, addr_rule_t [`NOC_NUM_RULES-1:0] map);
    node_id_t dst;
    dst.x = addr[`NOC_X_OFFSET +: `NOC_X_W];
    dst.y = addr[`NOC_Y_OFFSET +: `NOC_Y_W];
    for (int r = 0; r < `NOC_NUM_RULES; r++) begin
      if ((addr >= map[r].start_addr) && (addr < map[r].end_addr)) begin
        return map[r].dst;
      end
    end
    return dst;
  endfunction

  // Mix of rule hits, the overlap, exact end addresses and unmapped space
  function automatic addr_t pick_addr(logic [31:0] r);
    addr_t a;
    case (r[31:29])
      3'd0:    a = 32'h0000_1000 + {19'd0, r[12:0]};
      3'd1:    a = 32'h0000_2000 + {20'd0, r[11:0]};
      3'd2:    a = 32'h0000_3000 + {19'd0, r[12:0]};
      3'd3:    a = 32'h1000_0000 + {16'd0, r[15:0]};
      3'd4:    a = 32'h8000_0000 + {24'd0, r[7:0]};
      3'd5:    a = addr_map_i[r[1:0]].end_addr;
      default: a = r;
    endcase
    return a;
  endfunction

  task automatic report_failure(string msg);
    $display("%s", msg);
    $display("TB FAILED");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check_flit(string name, flit_t got, flit_t exp);
    if (got !== exp) begin
      report_failure($sformatf("mismatch at %0t: %s got %h expected %h",
                               $time, name, got, exp));
    end
  endtask

  task automatic check_count(string name, credit_cnt_t got, credit_cnt_t exp);
    if (got !== exp) begin
      report_failure($sformatf("mismatch at %0t: %s got %0d expected %0d",
                               $time, name, got, exp));
    end
  endtask

  task automatic check_src(string name, src_id_t got, src_id_t exp);
    if (got !== exp) begin
      report_failure($sformatf("mismatch at %0t: %s got %0d expected %0d",
                               $time, name, got, exp));
    end
  endtask

  task automatic check_ctrl(string name, logic [`NOC_NUM_INIT-1:0] got,
                            logic [`NOC_NUM_INIT-1:0] exp);
    if (got !== exp) begin
      report_failure($sformatf("mismatch at %0t: %s got %b expected %b",
                               $time, name, got, exp));
    end
  endtask

  // Lands a quarter period after the rising edge and clear of both edges
  task automatic wait_cycles(int n);
    repeat (n) @(posedge clk_i);
    #10;
  endtask

  // Request driver and downstream credit model run on the falling edge
  always @(negedge clk_i) begin
    int delay;
    if (!rst_i) begin
      for (int i = 0; i < `NOC_NUM_INIT; i++) begin
        if (!req_valid_i[i] || accepted[i]) begin
          req_valid_i[i] = 1'b0;
          if (traffic_on && (issued < NUM_REQS)) begin
            rng = xorshift32(rng);
            if (traffic_full || (rng[3:0] < 4'd9)) begin
              rng = xorshift32(rng);
              req_addr_i[i] = pick_addr(rng);
              rng = xorshift32(rng);
              req_data_i[i] = rng;
              req_valid_i[i] = 1'b1;
              issued++;
            end
          end
        end
      end
      // Each flit taken at the last rising edge occupies one buffer slot
      if (flit_seen) begin
        outstanding++;
        rng   = xorshift32(rng);
        delay = fast_credit ? 0 : int'(rng % 32'd6);
        credit_due.push_back(cycle + delay);
      end
      link_credit_i = 1'b0;
      if (!withhold && (credit_due.size() > 0) && (credit_due[0] <= cycle)) begin
        void'(credit_due.pop_front());
        link_credit_i = 1'b1;
        outstanding--;
      end
    end
  end

  // Acceptances fill the scoreboard queues and link flits drain them
  always @(posedge clk_i) begin
    flit_t exp_flit;
    flit_t got_flit;
    cycle++;
    flit_seen = 1'b0;
    if (cycle > TIMEOUT_CYCLES) begin
      report_failure($sformatf("timeout after %0d cycles before the test finished", cycle));
    end else if (!rst_i) begin
      for (int i = 0; i < `NOC_NUM_INIT; i++) begin
        accepted[i] = req_valid_i[i] && req_ready_o[i];
        if (accepted[i]) begin
          exp_flit.dst  = route_ref(req_addr_i[i], addr_map_i);
          exp_flit.src  = src_id_t'(i);
          exp_flit.addr = req_addr_i[i];
          exp_flit.data = req_data_i[i];
          if (i == 0) exp_q0.push_back(exp_flit);
          else exp_q1.push_back(exp_flit);
        end
      end
      if (link_valid_o) begin
        got_flit = link_flit_o;
        if (outstanding >= `NOC_CREDITS) begin
          report_failure("link sent a flit while the downstream buffer was full");
        end else if ((got_flit.src == 1'b0) ? (exp_q0.size() == 0) : (exp_q1.size() == 0)) begin
          report_failure($sformatf("flit from source %0d arrived with no request waiting",
                                   got_flit.src));
        end else begin
          if (got_flit.src == 1'b0) exp_flit = exp_q0.pop_front();
          else exp_flit = exp_q1.pop_front();
          check_flit("link_flit_o", got_flit, exp_flit);
          if (fair_check && have_last) begin
            check_src("link_flit_o.src", got_flit.src, src_id_t'(~last_src));
          end
          last_src  = got_flit.src;
          have_last = 1'b1;
          flit_seen = 1'b1;
        end
      end
    end
  end

  initial begin
    clk_i         = 1'b0;
    rst_i         = 1'b1;
    req_valid_i   = '0;
    req_addr_i    = '0;
    req_data_i    = '0;
    link_credit_i = 1'b0;
    // Rules 0 and 1 overlap from 0x2000 to 0x2fff
    addr_map_i[0] = make_rule(1, 2, 32'h0000_1000, 32'h0000_3000);
    addr_map_i[1] = make_rule(3, 0, 32'h0000_2000, 32'h0000_5000);
    addr_map_i[2] = make_rule(5, 6, 32'h1000_0000, 32'h1001_0000);
    addr_map_i[3] = make_rule(7, 7, 32'h8000_0000, 32'h8000_0100);
    rng          = 32'h7eb2_2a38;
    cycle        = 0;
    issued       = 0;
    outstanding  = 0;
    accepted     = '0;
    flit_seen    = 1'b0;
    traffic_on   = 1'b0;
    traffic_full = 1'b0;
    withhold     = 1'b0;
    fast_credit  = 1'b0;
    fair_check   = 1'b0;
    have_last    = 1'b0;
    last_src     = '0;

    repeat (5) @(negedge clk_i);
    rst_i = 1'b0;
    wait_cycles(1);
    check_ctrl("link_valid_o", {{(`NOC_NUM_INIT-1){1'b0}}, link_valid_o}, '0);
    check_ctrl("req_ready_o", req_ready_o, '1);

    // Random traffic with random credit return delays
    traffic_on = 1'b1;
    while (issued < 80) wait_cycles(1);

    // Downstream holds every credit and the link must stall at the limit
    traffic_full = 1'b1;
    withhold     = 1'b1;
    wait_cycles(24);
    check_count("outstanding flits", credit_cnt_t'(outstanding), credit_cnt_t'(`NOC_CREDITS));
    check_ctrl("link_valid_o", {{(`NOC_NUM_INIT-1){1'b0}}, link_valid_o}, '0);
    check_ctrl("req_ready_o", req_ready_o, '0);

    // Credits flow back at once while both initiators stay valid
    withhold    = 1'b0;
    fast_credit = 1'b1;
    wait_cycles(8);
    fair_check = 1'b1;
    wait_cycles(40);
    fair_check = 1'b0;
    traffic_on = 1'b0;

    while ((req_valid_i != '0) || (exp_q0.size() != 0) || (exp_q1.size() != 0) ||
           (credit_due.size() != 0) || flit_seen) begin
      wait_cycles(1);
    end
    // Any flit arriving now would find an empty queue
    wait_cycles(10);
    check_ctrl("req_ready_o", req_ready_o, '1);
    $display("TB PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* noc_inject_top.f */
+incdir+.
noc_pkg.sv
noc_route_comp.sv
noc_init_port.sv
noc_link_arb.sv
noc_inject_top.sv
tb_noc_inject_top.sv

/* run_sim.sh */
#!/bin/sh
# Compile the injection tile with its testbench and run it
set -e

cd "$(dirname "$0")"

verilator --binary --top-module tb_noc_inject_top \
  -f noc_inject_top.f -o sim_noc_inject_top

./obj_dir/sim_noc_inject_top
